/* compile.f */
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/l1i_cache.sv
rtl/ifu.sv
rtl/imem_model.sv
rtl/fetch_top.sv
dv/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch front end simulation with Verilator.
set -e

verilator --binary -j 0 -f compile.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log

/* dv/fetch_tb.sv */
module fetch_tb;

  localparam int CREDITS = 2;

  typedef struct {
    string       name;
    int          rd0;       // delivery index for a redirect or -2 for one during the first miss.
    int          rd1;
    logic [31:0] tgt;
    int          cnt;
    int          delay;     // credit return delay or -1 for a random one.
    int          step;      // one lookup per delivery.
    int          fence;     // fence.i at word 4.
    int          upd;       // 1 rewrites word 1 in memory and model and 2 in memory only.
    int          exp_miss;
  } test_t;

  logic        clk;
  logic        rst;
  logic        fetch_en_i;
  logic        redirect_valid_i;
  logic [31:0] redirect_pc_i;
  logic        credit_return_i;
  logic        imem_we_i;
  logic [31:0] imem_waddr_i;
  logic [31:0] imem_wdata_i;
  logic        inst_valid_o;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic [31:0] miss_count_o;

  test_t       tests [7];
  logic [31:0] ref_mem [32];
  int          seed = 44722;
  int          rq [$];  // cycles at which a credit goes back.

  fetch_top #(.L1I_IDX_W(3), .MEM_AW(8), .MEM_LATENCY(3), .CREDITS(CREDITS)) i_fetch_top (
    .clk(clk), .rst(rst), .fetch_en_i(fetch_en_i), .redirect_valid_i(redirect_valid_i),
    .redirect_pc_i(redirect_pc_i), .credit_return_i(credit_return_i),
    .imem_we_i(imem_we_i), .imem_waddr_i(imem_waddr_i), .imem_wdata_i(imem_wdata_i),
    .inst_valid_o(inst_valid_o), .inst_o(inst_o), .pc_o(pc_o), .miss_count_o(miss_count_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // ======================================================================
  // one table entry
  // ======================================================================

  task automatic run_test(input test_t t);
    int          n;
    int          cyc;
    int          idle;
    int          t0;
    int          d;
    int          kick;
    logic        v;
    logic [31:0] ai;
    logic [31:0] ap;
    logic [31:0] exp_pc;
    n = 0;
    cyc = 0;
    idle = 0;
    t0 = 0;
    kick = 0;
    exp_pc = 32'h0;
    rq.delete();
    // reset for 10 cycles, then load the program with fetch disabled.
    for (int c = 0; c < 10; c++)
    begin
      @(posedge clk);
      rst              <= 1'b1;
      fetch_en_i       <= 1'b0;
      redirect_valid_i <= 1'b0;
      credit_return_i  <= 1'b0;
      imem_we_i        <= 1'b0;
    end
    for (int w = 0; w < 32; w++)
    begin
      ref_mem[w] = {12'(w), 20'h00013};  // addi x0, x0, w.
      if (t.fence != 0 && w == 4)
      begin
        ref_mem[w] = 32'h0000_100f;
      end
      @(posedge clk);
      rst          <= 1'b0;
      imem_we_i    <= 1'b1;
      imem_waddr_i <= 32'(w * 4);
      imem_wdata_i <= ref_mem[w];
    end
    @(posedge clk);
    imem_we_i  <= 1'b0;
    fetch_en_i <= 1'b1;
    @(negedge clk);
    check({t.name, " reset misses"}, 32'd0, miss_count_o);
    while (n < t.cnt)
    begin
      @(negedge clk);
      v  = inst_valid_o;
      ai = inst_o;
      ap = pc_o;
      @(posedge clk);
      cyc++;
      idle++;
      credit_return_i  <= 1'b0;
      redirect_valid_i <= 1'b0;
      imem_we_i        <= 1'b0;
      if (t.step != 0)
      begin
        fetch_en_i <= 1'b0;
      end
      if (kick != 0)
      begin
        fetch_en_i <= 1'b1;
        kick = 0;
      end
      if (rq.size() > 0 && rq[0] <= cyc)
      begin
        credit_return_i <= 1'b1;
        void'(rq.pop_front());
      end
      if (t.rd0 == -2 && cyc == 1)
      begin
        redirect_valid_i <= 1'b1;  // pc 0 read is in flight here.
        redirect_pc_i    <= t.tgt;
        exp_pc = t.tgt;
      end
      if (v)
      begin
        idle = 0;
        check({t.name, " pc"}, exp_pc, ap);
        check({t.name, " inst"}, ref_mem[exp_pc[6:2]], ai);
        if (n == 0)
        begin
          t0 = cyc;
        end
        if (t.delay >= 50 && n == CREDITS)
        begin
          check({t.name, " credit window"}, 32'd1, {31'd0, (cyc - t0) >= 50});
        end
        d = t.delay;
        if (d < 0)
        begin
          d = ($random(seed) & 7) + 1;
        end
        rq.push_back(cyc + d);
        exp_pc = exp_pc + 32'd4;
        if (t.upd != 0 && n == 5)
        begin
          imem_we_i    <= 1'b1;
          imem_waddr_i <= 32'h4;
          imem_wdata_i <= 32'h7ff0_0093;
          if (t.upd == 1)
          begin
            ref_mem[1] = 32'h7ff0_0093;
          end
        end
        if (n == t.rd0 || n == t.rd1)
        begin
          redirect_valid_i <= 1'b1;
          redirect_pc_i    <= t.tgt;
          exp_pc = t.tgt;
          kick = t.step;
        end
        else if (t.step != 0 && n + 1 < t.cnt)
        begin
          fetch_en_i <= 1'b1;
        end
        n++;
      end
      if (idle > 200)
      begin
        $display("no instruction arrived within 200 cycles in test %s", t.name);
        $display("CHECKS FAILED");
        $fatal(1);
      end
    end
    @(negedge clk);
    if (t.exp_miss >= 0)
    begin
      check({t.name, " misses"}, 32'(t.exp_miss), miss_count_o);
    end
  endtask

  // ======================================================================
  // test table
  // ======================================================================

  initial
  begin
    rst              = 1'b1;
    fetch_en_i       = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = 32'h0;
    credit_return_i  = 1'b0;
    imem_we_i        = 1'b0;
    imem_waddr_i     = 32'h0;
    imem_wdata_i     = 32'h0;
    tests[0] = '{"seq",        -1, -1, 32'h0,  10,  3, 0, 0, 0, -1};
    tests[1] = '{"seq_rand",   -1, -1, 32'h0,  10, -1, 0, 0, 0, -1};
    tests[2] = '{"loop",        3,  7, 32'h0,  12,  1, 1, 0, 0,  4};
    tests[3] = '{"fence",       3,  8, 32'h0,  13,  1, 1, 1, 1,  9};
    tests[4] = '{"stale",       3,  8, 32'h0,  13,  1, 1, 0, 2,  5};
    tests[5] = '{"credit",     -1, -1, 32'h0,   6, 60, 0, 0, 0, -1};
    tests[6] = '{"redir_miss", -2, -1, 32'h40,  6,  2, 0, 0, 0, -1};
    for (int i = 0; i < 7; i++)
    begin
      run_test(tests[i]);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* rtl/fetch_top.sv */
module fetch_top #(
  parameter int L1I_IDX_W   = 3,
  parameter int MEM_AW      = 8,
  parameter int MEM_LATENCY = 3,
  parameter int CREDITS     = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_en_i,
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc_i,
  input  logic                       credit_return_i,
  input  logic                       imem_we_i,
  input  logic [fetch_pkg::xlen-1:0] imem_waddr_i,
  input  logic [fetch_pkg::xlen-1:0] imem_wdata_i,
  output logic                       inst_valid_o,
  output logic [fetch_pkg::xlen-1:0] inst_o,
  output logic [fetch_pkg::xlen-1:0] pc_o,
  output logic [31:0]                miss_count_o
);

  logic [fetch_pkg::xlen-1:0] fetch_pc;  // pc being looked up.
  logic                       pc_advance;
  logic [fetch_pkg::xlen-1:0] lookup_addr;
  logic                       hit;
  logic [fetch_pkg::xlen-1:0] hit_data;
  logic                       rd_req;
  logic [fetch_pkg::xlen-1:0] rd_addr;
  logic                       rd_valid;
  logic [fetch_pkg::xlen-1:0] rd_data;
  logic                       fill;
  logic [fetch_pkg::xlen-1:0] fill_addr;
  logic [fetch_pkg::xlen-1:0] fill_data;
  logic                       flush;

  pc_gen i_pc_gen (
    .clk(clk), .rst(rst), .advance_i(pc_advance), .redirect_valid_i(redirect_valid_i),
    .redirect_pc_i(redirect_pc_i), .pc_o(fetch_pc)
  );

  ifu #(.L1I_IDX_W(L1I_IDX_W), .CREDITS(CREDITS)) i_ifu (
    .clk(clk), .rst(rst), .fetch_en_i(fetch_en_i), .pc_i(fetch_pc),
    .credit_return_i(credit_return_i), .hit_i(hit), .hit_data_i(hit_data),
    .rd_valid_i(rd_valid), .rd_data_i(rd_data), .pc_advance_o(pc_advance),
    .lookup_addr_o(lookup_addr), .rd_req_o(rd_req), .rd_addr_o(rd_addr), .fill_o(fill),
    .fill_addr_o(fill_addr), .fill_data_o(fill_data), .flush_o(flush),
    .inst_valid_o(inst_valid_o), .inst_o(inst_o), .pc_o(pc_o), .miss_count_o(miss_count_o)
  );

  l1i_cache #(.L1I_IDX_W(L1I_IDX_W)) i_l1i_cache (
    .clk(clk), .rst(rst), .lookup_addr_i(lookup_addr), .fill_i(fill),
    .fill_addr_i(fill_addr), .fill_data_i(fill_data), .flush_i(flush),
    .hit_o(hit), .hit_data_o(hit_data)
  );

  // testbench loads the program through the write port.
  imem_model #(.MEM_AW(MEM_AW), .MEM_LATENCY(MEM_LATENCY)) i_imem_model (
    .clk(clk), .rst(rst), .rd_req_i(rd_req), .rd_addr_i(rd_addr), .we_i(imem_we_i),
    .waddr_i(imem_waddr_i), .wdata_i(imem_wdata_i), .rd_valid_o(rd_valid),
    .rd_data_o(rd_data)
  );

endmodule

/* rtl/imem_model.sv */
module imem_model #(
  parameter int MEM_AW      = 8,
  parameter int MEM_LATENCY = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_req_i,
  input  logic [fetch_pkg::xlen-1:0] rd_addr_i,
  input  logic                       we_i,
  input  logic [fetch_pkg::xlen-1:0] waddr_i,
  input  logic [fetch_pkg::xlen-1:0] wdata_i,
  output logic                       rd_valid_o,
  output logic [fetch_pkg::xlen-1:0] rd_data_o
);

  localparam int DEPTH = 1 << MEM_AW;

  logic [fetch_pkg::xlen-1:0] mem [DEPTH];
  logic [MEM_LATENCY-1:0]     vld_q;
  logic [fetch_pkg::xlen-1:0] data_q [MEM_LATENCY];
  logic [MEM_AW-1:0]          rd_idx;
  logic [MEM_AW-1:0]          wr_idx;

  // word addressed.
  assign rd_idx = rd_addr_i[MEM_AW+1:2];
  assign wr_idx = waddr_i[MEM_AW+1:2];

  always_ff @(posedge clk)
  begin
    if (we_i)
    begin
      mem[wr_idx] <= wdata_i;
    end
  end

  // ======================================================================
  // read pipeline
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vld_q <= '0;
    end
    else
    begin
      vld_q[0] <= rd_req_i;
      for (int i = 1; i < MEM_LATENCY; i++)
      begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // data sampled at the request, so a later write leaves it alone.
  always_ff @(posedge clk)
  begin
    if (rd_req_i)
    begin
      data_q[0] <= mem[rd_idx];
    end
    for (int i = 1; i < MEM_LATENCY; i++)
    begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign rd_valid_o = vld_q[MEM_LATENCY-1];
  assign rd_data_o  = data_q[MEM_LATENCY-1];

endmodule

/* rtl/ifu.sv */
module ifu #(
  parameter int L1I_IDX_W = 3,
  parameter int CREDITS   = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_en_i,
  input  logic [fetch_pkg::xlen-1:0] pc_i,
  input  logic                       credit_return_i,
  input  logic                       hit_i,
  input  logic [fetch_pkg::xlen-1:0] hit_data_i,
  input  logic                       rd_valid_i,
  input  logic [fetch_pkg::xlen-1:0] rd_data_i,
  output logic                       pc_advance_o,
  output logic [fetch_pkg::xlen-1:0] lookup_addr_o,
  output logic                       rd_req_o,
  output logic [fetch_pkg::xlen-1:0] rd_addr_o,
  output logic                       fill_o,
  output logic [fetch_pkg::xlen-1:0] fill_addr_o,
  output logic [fetch_pkg::xlen-1:0] fill_data_o,
  output logic                       flush_o,
  output logic                       inst_valid_o,
  output logic [fetch_pkg::xlen-1:0] inst_o,
  output logic [fetch_pkg::xlen-1:0] pc_o,
  output logic [31:0]                miss_count_o
);

  localparam int CW    = $clog2(CREDITS + 1);
  localparam int TAG_W = fetch_pkg::xlen - L1I_IDX_W - 2;

  fetch_pkg::fetch_state_e state_q, state_d;

  logic [CW-1:0]              credits_q;
  logic                       credit_ok;
  logic [TAG_W-1:0]           req_tag_q;  // line tag and index of the outstanding read.
  logic [L1I_IDX_W-1:0]       req_idx_q;
  logic                       same_pc;
  logic [fetch_pkg::xlen-1:0] hold_q;
  logic                       deliver;
  logic [fetch_pkg::xlen-1:0] deliver_data;

  assign credit_ok = (credits_q != '0);
  assign same_pc   = ({req_tag_q, req_idx_q} == pc_i[fetch_pkg::xlen-1:2]);

  assign lookup_addr_o = pc_i;
  assign rd_addr_o     = pc_i;
  assign fill_addr_o   = {req_tag_q, req_idx_q, 2'b00};
  assign fill_data_o   = rd_data_i;
  assign pc_advance_o  = deliver;
  assign flush_o       = deliver && (deliver_data == fetch_pkg::fence_i_inst);

  // ======================================================================
  // fetch control
  // ======================================================================

  always_comb
  begin
    state_d      = state_q;
    deliver      = 1'b0;
    deliver_data = hit_data_i;
    rd_req_o     = 1'b0;
    fill_o       = 1'b0;
    case (state_q)
      fetch_pkg::s_lookup:
      begin
        if (fetch_en_i && hit_i)
        begin
          deliver = credit_ok;  // stay and look again until a credit returns.
        end
        else if (fetch_en_i)
        begin
          rd_req_o = 1'b1;
          state_d  = fetch_pkg::s_wait_mem;
        end
      end
      fetch_pkg::s_wait_mem:
      begin
        deliver_data = rd_data_i;
        if (rd_valid_i)
        begin
          fill_o = 1'b1;  // fills even when dropped.
          deliver = same_pc && credit_ok;
          state_d = (same_pc && !credit_ok) ? fetch_pkg::s_hold : fetch_pkg::s_lookup;
        end
      end
      fetch_pkg::s_hold:
      begin
        deliver_data = hold_q;
        deliver      = same_pc && credit_ok;
        if (!same_pc || credit_ok)
        begin
          state_d = fetch_pkg::s_lookup;
        end
      end
      default: state_d = fetch_pkg::s_lookup;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= fetch_pkg::s_lookup;
      inst_valid_o <= 1'b0;
      miss_count_o <= '0;
    end
    else
    begin
      state_q      <= state_d;
      inst_valid_o <= deliver;
      if (rd_req_o)
      begin
        miss_count_o <= miss_count_o + 32'd1;
      end
    end
  end

  // ======================================================================
  // decode credits
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credits_q <= CW'(CREDITS);
    end
    else if (deliver && !credit_return_i)
    begin
      credits_q <= credits_q - CW'(1);
    end
    else if (!deliver && credit_return_i && credits_q != CW'(CREDITS))
    begin
      credits_q <= credits_q + CW'(1);
    end
  end

  // payload.
  always_ff @(posedge clk)
  begin
    if (rd_req_o)
    begin
      req_tag_q <= pc_i[fetch_pkg::xlen-1:L1I_IDX_W+2];
      req_idx_q <= pc_i[L1I_IDX_W+1:2];
    end
    if (state_q == fetch_pkg::s_wait_mem && rd_valid_i)
    begin
      hold_q <= rd_data_i;
    end
    if (deliver)
    begin
      inst_o <= deliver_data;
      pc_o   <= pc_i;
    end
  end

endmodule

/* rtl/l1i_cache.sv */
module l1i_cache #(
  parameter int L1I_IDX_W = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::xlen-1:0] lookup_addr_i,
  input  logic                       fill_i,
  input  logic [fetch_pkg::xlen-1:0] fill_addr_i,
  input  logic [fetch_pkg::xlen-1:0] fill_data_i,
  input  logic                       flush_i,
  output logic                       hit_o,
  output logic [fetch_pkg::xlen-1:0] hit_data_o
);

  localparam int LINES = 1 << L1I_IDX_W;
  localparam int TAG_W = fetch_pkg::xlen - L1I_IDX_W - 2;

  // ======================================================================
  // storage, one word per line
  // ======================================================================

  logic [TAG_W-1:0]           tag_q  [LINES];
  logic [fetch_pkg::xlen-1:0] data_q [LINES];
  logic [LINES-1:0]           valid_q;

  logic [L1I_IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0]     lk_tag;
  logic [L1I_IDX_W-1:0] fl_idx;
  logic [TAG_W-1:0]     fl_tag;

  // address split is tag | index | word offset.
  assign lk_tag = lookup_addr_i[fetch_pkg::xlen-1:L1I_IDX_W+2];
  assign lk_idx = lookup_addr_i[L1I_IDX_W+1:2];
  assign fl_tag = fill_addr_i[fetch_pkg::xlen-1:L1I_IDX_W+2];
  assign fl_idx = fill_addr_i[L1I_IDX_W+1:2];

  // ======================================================================
  // lookup
  // ======================================================================

  assign hit_o      = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign hit_data_o = data_q[lk_idx];

  // ======================================================================
  // fill and flush
  // ======================================================================

  // flush wins over a fill in the same cycle.
  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_i)
    begin
      valid_q[fl_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      tag_q[fl_idx]  <= fl_tag;
      data_q[fl_idx] <= fill_data_i;
    end
  end

endmodule

/* rtl/pc_gen.sv */
module pc_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       advance_i,
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc_i,
  output logic [fetch_pkg::xlen-1:0] pc_o
);

  logic [fetch_pkg::xlen-1:0] pc_q;
  logic [fetch_pkg::xlen-1:0] pc_d;

  // redirect beats advance.
  always_comb
  begin
    if (redirect_valid_i)
    begin
      pc_d = redirect_pc_i;
    end
    else if (advance_i)
    begin
      pc_d = pc_q + 32'd4;  // no compressed, always +4.
    end
    else
    begin
      pc_d = pc_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= fetch_pkg::reset_pc;
    end
    else
    begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // ======================================================================
  // widths and constants
  // ======================================================================

  localparam int unsigned xlen = 32;  // address and instruction width.

  // pc after reset.
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // fence.i invalidates the whole instruction cache when delivered.
  localparam logic [31:0] fence_i_inst = 32'h0000_100f;

  // ======================================================================
  // fetch unit states
  // ======================================================================

  // s_lookup   : cache lookup of the current pc, hit delivers.
  // s_wait_mem : one read outstanding, waiting for the response.
  // s_hold     : response captured, waiting for a decode credit.
  typedef enum logic [1:0]
  {
    s_lookup   = 2'd0,
    s_wait_mem = 2'd1,
    s_hold     = 2'd2
  } fetch_state_e;

endpackage
